// File: common/lsu_pkg.sv
// shared widths, access encodings and controller states of the load/store unit

package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int XLEN   = 32;           // data and address width
  localparam int NBYTES = XLEN / 8;     // byte lanes on the data bus
  localparam int OFFS_W = 2;            // in-word byte offset
  localparam int BYTE_W = 8;            // one lane
  localparam int HALF_W = 16;           // two lanes

  ////////////////////
  // encodings
  ////////////////////

  // access size as delivered by the execute stage
  typedef enum logic [1:0] {
    WORD     = 2'b00,
    HALF     = 2'b01,
    BYTE     = 2'b10,
    BYTE_ALT = 2'b11                    // decodes as a byte access
  } data_type_e;

  // how loaded halves and bytes are widened to XLEN
  typedef enum logic [1:0] {
    EXT_ZERO     = 2'b00,
    EXT_SIGN     = 2'b01,
    EXT_ONES     = 2'b10,
    EXT_SIGN_ALT = 2'b11                // same as EXT_SIGN
  } sign_ext_e;

  ////////////////////
  // controller
  ////////////////////

  // bus handshake states
  //   IDLE                  no access outstanding, request passes straight through
  //   WAIT_RVALID           granted, waiting for the read/write response
  //   WAIT_RVALID_EX_STALL  granted while execute was stalled, no new request
  //   IDLE_EX_STALL         response seen, execute still stalled
  typedef enum logic [1:0] {
    IDLE,
    WAIT_RVALID,
    WAIT_RVALID_EX_STALL,
    IDLE_EX_STALL
  } lsu_state_e;

endpackage

// File: rtl/lsu_request_format.sv
// request formatter, builds bus address, byte enables and rotated store data
`timescale 1ns/100ps

module lsu_request_format import lsu_pkg::*;
(
  input  logic              data_req_ex_i,
  input  logic              data_we_ex_i,
  input  data_type_e        data_type_ex_i,
  input  logic [XLEN-1:0]   data_wdata_ex_i,
  input  logic [OFFS_W-1:0] data_reg_offset_ex_i,
  input  logic [XLEN-1:0]   operand_a_ex_i,
  input  logic [XLEN-1:0]   operand_b_ex_i,
  input  logic              addr_useincr_ex_i,
  input  logic              data_misaligned_ex_i,

  output logic [XLEN-1:0]   data_addr_o,
  output logic              data_we_o,
  output logic [NBYTES-1:0] data_be_o,
  output logic [XLEN-1:0]   data_wdata_o,
  output logic [OFFS_W-1:0] addr_offs_o,
  output logic              misaligned_o
);

  logic [XLEN-1:0]     data_addr_int;
  logic [OFFS_W-1:0]   wdata_offset;  // net rotation in bytes
  logic [NBYTES-1:0]   size_mask;     // lanes covered at offset 0
  logic [2*NBYTES-1:0] be_span;       // lanes of this word and of the next one
  logic [2*XLEN-1:0]   wdata_rot;

  // base + offset, or base alone
  assign data_addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_offs_o   = data_addr_int[OFFS_W-1:0];

  ////////////////////
  // byte enables
  ////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      WORD:           size_mask = 4'b1111;
      HALF:           size_mask = 4'b0011;
      BYTE, BYTE_ALT: size_mask = 4'b0001;
      default:        size_mask = 4'b0001;
    endcase
  end

  // shift into an 8 lane window, whatever falls past lane 3 belongs to the next word
  assign be_span = {{NBYTES{1'b0}}, size_mask} << addr_offs_o;

  // second part only gets the spilled lanes, e.g. word at offset 2 -> 0011
  assign data_be_o = data_misaligned_ex_i ? be_span[2*NBYTES-1:NBYTES]
                                          : be_span[NBYTES-1:0];

  // first part that spills over the word boundary needs another access
  assign misaligned_o = data_req_ex_i & ~data_misaligned_ex_i & (|be_span[2*NBYTES-1:NBYTES]);

  ////////////////////
  // write data
  ////////////////////

  // rotate up so register byte reg_offset lands on lane addr_offs (mod 4)
  assign wdata_offset = addr_offs_o - data_reg_offset_ex_i;
  assign wdata_rot    = {data_wdata_ex_i, data_wdata_ex_i} << (BYTE_W * wdata_offset);

  assign data_wdata_o = wdata_rot[2*XLEN-1:XLEN];  // upper copy holds the rotated word
  assign data_addr_o  = data_addr_int;
  assign data_we_o    = data_we_ex_i;

  // an execute request must never put an X address on the bus
  always_comb
  begin
    if (data_req_ex_i)
      assert (!$isunknown(data_addr_int))
        else $error("lsu: request with unknown address %h", data_addr_int);
  end

endmodule

// File: load_align/load_align.sv
// load aligner, selects and extends loaded lanes and joins misaligned halves
`timescale 1ns/100ps

module load_align import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [XLEN-1:0]   data_rdata_i,

  input  logic              data_we_ex_i,
  input  data_type_e        data_type_ex_i,
  input  sign_ext_e         data_sign_ext_ex_i,
  input  logic [OFFS_W-1:0] addr_offs_i,           // low address bits of the request
  input  logic              data_misaligned_ex_i,  // second part in execute
  input  logic              misaligned_i,          // first part needs a second one

  output logic [XLEN-1:0]   data_rdata_ex_o
);

  // attributes of the access in flight, latched at grant
  data_type_e        data_type_q;
  logic [OFFS_W-1:0] rdata_offset_q;
  sign_ext_e         data_sign_ext_q;
  logic              data_we_q;

  logic [XLEN-1:0]   rdata_q;        // first half of a misaligned load, or last result
  logic              spill;          // access crosses the word boundary
  logic [2*XLEN-1:0] rdata_window;   // new word above, low part below
  logic [2*XLEN-1:0] rdata_shift;
  logic [XLEN-1:0]   rdata_aligned;  // wanted bytes moved down to lane 0
  logic              fill_bit;
  logic [XLEN-1:0]   rdata_ext;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q     <= WORD;
      rdata_offset_q  <= '0;
      data_sign_ext_q <= EXT_ZERO;
      data_we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      data_type_q     <= data_type_ex_i;
      rdata_offset_q  <= addr_offs_i;
      data_sign_ext_q <= data_sign_ext_ex_i;
      data_we_q       <= data_we_ex_i;
    end
  end

  ////////////////////
  // alignment
  ////////////////////

  // second part keeps the offset of the first, so the registered
  // size and offset tell whether the older bytes come from rdata_q
  assign spill = ((data_type_q == WORD) && (rdata_offset_q != '0)) ||
                 ((data_type_q == HALF) && (rdata_offset_q == 2'b11));

  assign rdata_window  = {data_rdata_i, spill ? rdata_q : data_rdata_i};
  assign rdata_shift   = rdata_window >> (BYTE_W * rdata_offset_q);
  assign rdata_aligned = rdata_shift[XLEN-1:0];  // e.g. word at 1 -> {new[7:0], old[31:8]}

  ////////////////////
  // extension
  ////////////////////

  always_comb
  begin
    // msb of the loaded field, used when sign extending
    case (data_type_q)
      HALF:           fill_bit = rdata_aligned[HALF_W-1];
      BYTE, BYTE_ALT: fill_bit = rdata_aligned[BYTE_W-1];
      default:        fill_bit = rdata_aligned[XLEN-1];
    endcase

    case (data_sign_ext_q)
      EXT_ZERO: fill_bit = 1'b0;
      EXT_ONES: fill_bit = 1'b1;
      default:  ;                    // sign, keep the msb
    endcase

    case (data_type_q)
      WORD:           rdata_ext = rdata_aligned;  // assembly only, nothing to widen
      HALF:           rdata_ext = {{(XLEN-HALF_W){fill_bit}}, rdata_aligned[HALF_W-1:0]};
      BYTE, BYTE_ALT: rdata_ext = {{(XLEN-BYTE_W){fill_bit}}, rdata_aligned[BYTE_W-1:0]};
      default:        rdata_ext = rdata_aligned;
    endcase
  end

  // result register, raw word for a first part and the final value otherwise
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !data_we_q)
    begin
      if (data_misaligned_ex_i || misaligned_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // live value on rvalid, held copy afterwards
  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: lsu_ctrl/lsu_ctrl.sv
// bus handshake controller, tracks outstanding requests and drives ready / busy
`timescale 1ns/100ps

module lsu_ctrl import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_ex_i,   // execute wants an access
  input  logic data_gnt_i,      // bus accepted the request
  input  logic data_rvalid_i,   // response for the granted request
  input  logic ex_valid_i,      // execute stage moves on this cycle

  output logic data_req_o,
  output logic lsu_ready_ex_o,  // execute may leave the access
  output logic lsu_ready_wb_o,  // writeback may take the result
  output logic busy_o
);

  lsu_state_e state_q, state_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      // nothing in flight, request goes out directly
      IDLE:
      begin
        data_req_o = data_req_ex_i;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;  // hold execute until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      // response pending, next request may only go out with rvalid
      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        if (data_rvalid_i)
        begin
          data_req_o = data_req_ex_i;  // back to back access
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;         // retry the request from IDLE
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      // granted during an execute stall; the stalled instruction still sits
      // in execute, so issuing now would repeat it
      WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;      // stall over, wait normally
      end

      // result is held in load_align, just wait out the stall
      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  assign busy_o = (state_q != IDLE) | data_req_o;  // any wait state or a live request

  ////////////////////
  // bus protocol checks
  ////////////////////

  // every rvalid belongs to a grant, so none can show up with nothing outstanding
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) |-> !data_rvalid_i)
    else $error("lsu: rvalid while idle");

  // the memory may only grant the next request together with the pending rvalid
  assert property (@(posedge clk) disable iff (!rst_n)
    ((state_q == WAIT_RVALID) && data_gnt_i) |-> data_rvalid_i)
    else $error("lsu: grant before rvalid of the previous request");

endmodule

// File: rtl/lsu_top.sv
// load/store unit top, ties request formatting, load alignment and bus control together
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // data memory bus
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output logic [XLEN-1:0]   data_addr_o,
  output logic              data_we_o,
  output logic [NBYTES-1:0] data_be_o,
  output logic [XLEN-1:0]   data_wdata_o,
  input  logic [XLEN-1:0]   data_rdata_i,

  // from execute stage
  input  logic              data_we_ex_i,          // store when high
  input  data_type_e        data_type_ex_i,        // word, half or byte
  input  logic [XLEN-1:0]   data_wdata_ex_i,       // store data as held in the register
  input  logic [OFFS_W-1:0] data_reg_offset_ex_i,  // byte offset inside that register
  input  sign_ext_e         data_sign_ext_ex_i,    // load extension mode
  input  logic              data_req_ex_i,         // access request
  input  logic [XLEN-1:0]   operand_a_ex_i,        // base
  input  logic [XLEN-1:0]   operand_b_ex_i,        // offset
  input  logic              addr_useincr_ex_i,     // add operand b to the base
  input  logic              data_misaligned_ex_i,  // this is the second part
  input  logic              ex_valid_i,            // execute stage not stalled

  // to execute / writeback
  output logic [XLEN-1:0]   data_rdata_ex_o,
  output logic              data_misaligned_o,     // access needs a second part
  output logic              lsu_ready_ex_o,
  output logic              lsu_ready_wb_o,
  output logic              busy_o
);

  logic [OFFS_W-1:0] addr_offs;  // low address bits, store side to load side

  // store side: address, lanes, rotated write data
  lsu_request_format lsu_request_format_inst (
    .data_req_ex_i        (data_req_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_addr_o          (data_addr_o),
    .data_we_o            (data_we_o),
    .data_be_o            (data_be_o),
    .data_wdata_o         (data_wdata_o),
    .addr_offs_o          (addr_offs),
    .misaligned_o         (data_misaligned_o)
  );

  // read side: alignment, misaligned assembly, extension
  load_align load_align_inst (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_gnt_i           (data_gnt_i),
    .data_rvalid_i        (data_rvalid_i),
    .data_rdata_i         (data_rdata_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .addr_offs_i          (addr_offs),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_i         (data_misaligned_o),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

  // request / grant / rvalid sequencing
  lsu_ctrl lsu_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

// File: bench/tb_lsu.sv
// testbench for the load/store unit with memory model, vector driver and watchdog
`timescale 1ns/100ps

module tb_lsu import lsu_pkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              data_req_o;
  logic              data_gnt_i    = 1'b0;
  logic              data_rvalid_i = 1'b0;
  logic [XLEN-1:0]   data_addr_o;
  logic              data_we_o;
  logic [NBYTES-1:0] data_be_o;
  logic [XLEN-1:0]   data_wdata_o;
  logic [XLEN-1:0]   data_rdata_i  = '0;
  logic              data_we_ex_i;
  data_type_e        data_type_ex_i;
  logic [XLEN-1:0]   data_wdata_ex_i;
  logic [OFFS_W-1:0] data_reg_offset_ex_i;
  sign_ext_e         data_sign_ext_ex_i;
  logic              data_req_ex_i;
  logic [XLEN-1:0]   operand_a_ex_i;
  logic [XLEN-1:0]   operand_b_ex_i;
  logic              addr_useincr_ex_i;
  logic              data_misaligned_ex_i;
  logic              ex_valid_i;
  logic [XLEN-1:0]   data_rdata_ex_o;
  logic              data_misaligned_o;
  logic              lsu_ready_ex_o;
  logic              lsu_ready_wb_o;
  logic              busy_o;

  // test vectors as read from the file
  string       t_name[$];
  string       t_op[$];
  logic [1:0]  t_size[$];
  logic [1:0]  t_ext[$];
  logic [1:0]  t_roff[$];
  logic [31:0] t_base[$];
  logic [31:0] t_offs[$];
  logic [31:0] t_wdata[$];
  logic [35:0] t_exp[$];             // {be, wdata} for stores, result for loads

  int          ntests = 0;
  int          errors = 0;
  integer      seed   = 68252;

  logic [31:0] mem [0:63];           // word memory indexed by addr[7:2]
  int unsigned gnt_wait;             // cycles left before the next grant

  lsu_top lsu_top_inst (.*);

  always #20 clk = ~clk;             // 40 ns period

  //////////////////////
  // memory model
  //////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      data_rdata_i  <= '0;
      gnt_wait      <= 0;
      for (int i = 0; i < 64; i++)
        mem[i] <= '0;
    end
    else
    begin
      data_rvalid_i <= 1'b0;
      if (data_req_o && data_gnt_i)
      begin
        data_gnt_i    <= 1'b0;
        data_rvalid_i <= 1'b1;       // response one cycle after grant
        if (data_we_o)
        begin
          for (int b = 0; b < NBYTES; b++)
            if (data_be_o[b])
              mem[data_addr_o[7:2]][8*b +: 8] <= data_wdata_o[8*b +: 8];
        end
        else
          data_rdata_i <= mem[data_addr_o[7:2]];
        gnt_wait <= $unsigned($random(seed)) % 3;  // 0 to 2 extra cycles
      end
      else if (data_req_o)
      begin
        if (gnt_wait == 0)
          data_gnt_i <= 1'b1;
        else
          gnt_wait <= gnt_wait - 1;
      end
    end
  end

  //////////////////////
  // checks
  //////////////////////

  task automatic check(input string name, input logic [35:0] exp, input logic [35:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  // request is held until granted and its address must not move
  task automatic wait_grant(input string name);
    logic [31:0] addr0;
    bit          first;
    first = 1'b1;
    addr0 = '0;
    forever
    begin
      @(negedge clk);
      if (first)
        addr0 = data_addr_o;
      first = 1'b0;
      check({name, " req"}, 36'(1), 36'(data_req_o));
      check({name, " addr"}, 36'(addr0), 36'(data_addr_o));
      check({name, " busy"}, 36'(1), 36'(busy_o));
      check({name, " ready_ex"}, 36'(data_gnt_i), 36'(lsu_ready_ex_o));
      if (data_gnt_i)
        break;
    end
  endtask

  task automatic run_access(input int k);
    logic [31:0] addr;
    logic        exp_mis;
    logic [31:0] got;
    bit          stall;
    bit          store;
    int          errs0;
    errs0   = errors;
    stall   = (t_op[k] == "lds");
    store   = (t_op[k] == "st");
    addr    = t_base[k] + t_offs[k];
    // word off the boundary or halfword at offset 3
    exp_mis = ((t_size[k] == 2'd0) && (addr[1:0] != 2'd0)) ||
              ((t_size[k] == 2'd1) && (addr[1:0] == 2'd3));

    @(posedge clk);
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= store;
    data_type_ex_i       <= data_type_e'(t_size[k]);
    data_sign_ext_ex_i   <= sign_ext_e'(t_ext[k]);
    data_reg_offset_ex_i <= t_roff[k];
    operand_a_ex_i       <= t_base[k];
    operand_b_ex_i       <= t_offs[k];
    data_wdata_ex_i      <= t_wdata[k];
    data_misaligned_ex_i <= 1'b0;
    ex_valid_i           <= !stall;

    wait_grant(t_name[k]);
    check({t_name[k], " addr"}, 36'(addr), 36'(data_addr_o));
    check({t_name[k], " we"}, 36'(store), 36'(data_we_o));
    check({t_name[k], " misaligned"}, 36'(exp_mis), 36'(data_misaligned_o));
    if (store)
      check(t_name[k], t_exp[k], {data_be_o, data_wdata_o});

    // second part keeps the low address bits in the next word
    if (data_misaligned_o)
    begin
      @(posedge clk);
      data_misaligned_ex_i <= 1'b1;
      operand_a_ex_i       <= t_base[k] + 32'd4;
      wait_grant({t_name[k], " part2"});
      check({t_name[k], " part2 addr"}, 36'(addr + 32'd4), 36'(data_addr_o));
    end

    if (!stall)
    begin
      @(posedge clk);
      data_req_ex_i        <= 1'b0;  // access leaves execute once granted
      data_misaligned_ex_i <= 1'b0;
    end

    // result is live in the rvalid cycle
    do
    begin
      @(negedge clk);
      check({t_name[k], " busy"}, 36'(1), 36'(busy_o));
      if (stall)
        check({t_name[k], " stall req"}, 36'(0), 36'(data_req_o));
      else
        check({t_name[k], " ready_wb"}, 36'(data_rvalid_i), 36'(lsu_ready_wb_o));
    end
    while (!data_rvalid_i);
    got = data_rdata_ex_o;

    if (stall)
    begin
      // execute stays stalled so the held request must not reach the bus
      repeat (2)
      begin
        @(negedge clk);
        check({t_name[k], " stall req"}, 36'(0), 36'(data_req_o));
      end
      @(posedge clk);
      ex_valid_i    <= 1'b1;
      data_req_ex_i <= 1'b0;
      @(negedge clk);
      check({t_name[k], " held"}, t_exp[k], {4'h0, data_rdata_ex_o});
    end

    if (!store)
      check(t_name[k], t_exp[k], {4'h0, got});

    @(negedge clk);
    check({t_name[k], " idle busy"}, 36'(0), 36'(busy_o));
    if (!store)
      check({t_name[k], " held"}, t_exp[k], {4'h0, data_rdata_ex_o});

    if (errors == errs0)
      $display("test %s ok", t_name[k]);
    else
      $display("test %s failed", t_name[k]);
  endtask

  //////////////////////
  // vectors
  //////////////////////

  task automatic load_tests(output bit ok);
    int    fd;
    int    r;
    int    sz;
    int    ex;
    int    ro;
    string line;
    string nm;
    string op;
    logic [31:0] b;
    logic [31:0] o;
    logic [31:0] w;
    logic [35:0] e;
    ok = 1'b0;
    fd = $fopen("bench/lsu_tests.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while (!$feof(fd))
      begin
        line = "";
        r = $fgets(line, fd);
        if ((r > 0) && (line.len() > 1) && (line.getc(0) != "#"))
        begin
          r = $sscanf(line, "%s %s %d %d %d %h %h %h %h", nm, op, sz, ex, ro, b, o, w, e);
          if (r == 9)
          begin
            t_name.push_back(nm);
            t_op.push_back(op);
            t_size.push_back(sz[1:0]);
            t_ext.push_back(ex[1:0]);
            t_roff.push_back(ro[1:0]);
            t_base.push_back(b);
            t_offs.push_back(o);
            t_wdata.push_back(w);
            t_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // watchdog allows 50 cycles per vector
  initial
  begin
    wait (ntests > 0);
    repeat (ntests * 50) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", ntests * 50);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    bit ok;
    clk                  = 1'b0;
    rst_n                = 1'b0;
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = WORD;
    data_sign_ext_ex_i   = EXT_ZERO;
    data_reg_offset_ex_i = '0;
    data_wdata_ex_i      = '0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b1;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i           = 1'b1;

    load_tests(ok);
    if (!ok || (t_name.size() == 0))
    begin
      $display("cannot read any test from bench/lsu_tests.txt");
      $display("*** FAILED ***");
      $finish;
    end
    else
    begin
      ntests = t_name.size();
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      // idle outputs after reset
      check("reset", 36'h3, 36'({lsu_ready_ex_o, lsu_ready_wb_o}));
      check("reset", 36'h0, 36'({data_req_o, busy_o}));
      if (errors == 0)
        $display("test reset ok");
      else
        $display("test reset failed");

      for (int k = 0; k < ntests; k++)
        run_access(k);

      $display("tests %0d, errors %0d", ntests, errors);
      if (errors == 0)
        $display("*** PASSED ***");
      else
        $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

// File: bench/lsu_tests.txt
# name op(st ld lds=load with execute stall) size(0 word 1 half 2/3 byte) ext(0 zero 1/3 sign 2 ones)
# regoff base offset wdata expected (stores {be,wdata}, loads result)
st_w10     st  0 0 0 00000010 00000000 11223344 f11223344
st_w14     st  0 0 0 00000010 00000004 8899aabb f8899aabb
st_h20     st  1 0 0 00000020 00000000 0000c0de 30000c0de
st_h22     st  1 0 0 00000020 00000002 0000beef cbeef0000
st_b25     st  2 0 0 00000024 00000001 000000a1 20000a100
st_b27     st  2 0 1 00000024 00000003 0000b200 8b2000000
st_b24     st  2 0 2 00000024 00000000 00c30000 1000000c3
st_b26     st  3 0 3 00000024 00000002 d4000000 400d40000
ld_w10     ld  0 0 0 00000010 00000000 00000000 011223344
ld_w14     ld  0 0 0 00000010 00000004 00000000 08899aabb
ld_h22_z   ld  1 0 0 00000020 00000002 00000000 00000beef
ld_h22_s   ld  1 1 0 00000020 00000002 00000000 0ffffbeef
ld_h22_s3  ld  1 3 0 00000020 00000002 00000000 0ffffbeef
ld_h20_z   ld  1 0 0 00000020 00000000 00000000 00000c0de
ld_h20_o   ld  1 2 0 00000020 00000000 00000000 0ffffc0de
ld_h12_s   ld  1 1 0 00000010 00000002 00000000 000001122
ld_b24_s   ld  2 1 0 00000024 00000000 00000000 0ffffffc3
ld_b25_z   ld  2 0 0 00000024 00000001 00000000 0000000a1
ld_b26_o   ld  2 2 0 00000024 00000002 00000000 0ffffffd4
ld_b27_s   ld  2 1 0 00000024 00000003 00000000 0ffffffb2
ld_b25_alt ld  3 1 0 00000024 00000001 00000000 0ffffffa1
ld_b10_s   ld  2 1 0 00000010 00000000 00000000 000000044
ld_b10_o   ld  2 2 0 00000010 00000000 00000000 0ffffff44
ld_w11     ld  0 0 0 00000010 00000001 00000000 0bb112233
ld_w12     ld  0 0 0 00000010 00000002 00000000 0aabb1122
ld_w13     ld  0 0 0 00000010 00000003 00000000 099aabb11
ld_h13_z   ld  1 0 0 00000010 00000003 00000000 00000bb11
ld_h13_s   ld  1 1 0 00000010 00000003 00000000 0ffffbb11
st_w29     st  0 0 0 00000028 00000001 01020304 e02030401
ld_w28     ld  0 0 0 00000028 00000000 00000000 002030400
ld_w2c     ld  0 0 0 00000028 00000004 00000000 000000001
st_h33     st  1 0 0 00000030 00000003 0000abcd 8cd0000ab
ld_w30     ld  0 0 0 00000030 00000000 00000000 0cd000000
ld_w34     ld  0 0 0 00000030 00000004 00000000 0000000ab
stall_w14  lds 0 0 0 00000010 00000004 00000000 08899aabb
stall_b25  lds 2 0 0 00000024 00000001 00000000 0000000a1

// File: rv_lsu.f
common/lsu_pkg.sv
rtl/lsu_request_format.sv
load_align/load_align.sv
lsu_ctrl/lsu_ctrl.sv
rtl/lsu_top.sv
bench/tb_lsu.sv

// File: run.sh
#!/bin/sh
# build the lsu testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_lsu -o tb_lsu -f rv_lsu.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
